//--- run_sim.sh
#!/usr/bin/env bash
# build and run the runner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module runner_tb --Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vrunner_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+verilog
verilog/runner_pkg.sv
verilog/frame_sequencer.sv
verilog/track_store.sv
verilog/player_physics.sv
verilog/collision_judge.sv
verilog/runner_core.sv
verification/runner_tb.sv

//--- verification/runner_tb.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module runner_tb;

    import runner_pkg::*;

    typedef struct packed {
        logic        rst;     // reset before this row
        logic [3:0]  speed;
        logic [3:0]  ctl;     // left, duck, jump, right
        logic [7:0]  frames;  // frames this row is held for
        obstacle_t   obs;     // loaded before the first frame unless its kind is none
        logic [1:0]  lane;    // expected after every frame of the row
        logic        duck;
        logic        go;
    } row_t;

    localparam logic [3:0] BTN_NONE  = 4'b0000;
    localparam logic [3:0] BTN_LEFT  = 4'b1000;
    localparam logic [3:0] BTN_DUCK  = 4'b0100;
    localparam logic [3:0] BTN_JUMP  = 4'b0010;
    localparam logic [3:0] BTN_RIGHT = 4'b0001;
    localparam obstacle_t  NO_OBS    = '0;

    // speed table rows for speeds 1, 2, 4 and 8
    localparam int GRAVITY_TAB[4] = '{1, 4, 15, 60};
    localparam int DUCK_TAB[4]    = '{128, 64, 32, 16};
    localparam int JUMP_TAB[4]    = '{108, 220, 470, 360};
    localparam int STEP_TAB[4]    = '{1, 2, 4, 8};

    logic               clk_render = 1'b0;
    logic               reset;
    logic [3:0]         speed;
    controls_t          controls;
    logic [`GAP_W-1:0]  frame_gap;
    obstacle_t          obstacle_in;
    logic               obstacle_in_valid;
    logic               obstacle_in_ready;
    runner_status_t     status;
    logic               frame_done;

    row_t               rows[$];
    logic [31:0]        lfsr_state = 32'h6ab7_2ad4;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycle_count = 0;
    int                 cycle_limit = 1000000;  // replaced once the table is built

    // reference model state
    int                 m_lane, m_height, m_vel, m_dcnt, m_score, m_step;
    logic               m_go;
    logic [3:0]         m_prev;
    obstacle_t          m_track[$];

    runner_core u_dut (
        .clk_render        (clk_render),
        .reset             (reset),
        .speed             (speed),
        .controls          (controls),
        .frame_gap         (frame_gap),
        .obstacle_in       (obstacle_in),
        .obstacle_in_valid (obstacle_in_valid),
        .obstacle_in_ready (obstacle_in_ready),
        .status            (status),
        .frame_done        (frame_done)
    );

    always #20 clk_render = ~clk_render;  // 40 ns period

    always @(posedge clk_render) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    task automatic next_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    endtask

    task automatic pick_gap(output logic [`GAP_W-1:0] g);
        logic b;
        g = '0;
        for (int i = 0; i < 4; i++) begin
            next_bit(b);
            g = {g[`GAP_W-2:0], b};
        end
        if (g == '0) g = `GAP_W'(1);  // keeps the gap in 1..15
    endtask

    function automatic obstacle_t mk_obs(input logic [1:0] kind, input logic [1:0] lane,
                                         input int depth);
        mk_obs = obstacle_t'({kind, lane, `DEPTH_W'(depth)});
    endfunction

    // gravity, duck length, jump strength and step per speed
    task automatic speed_table(input logic [3:0] spd, output int grav, output int dlen,
                               output int jmp, output int step);
        int idx;
        case (spd)
            4'd2:    idx = 1;
            4'd4:    idx = 2;
            4'd8:    idx = 3;
            default: idx = 0;   // unlisted speeds run the slowest row
        endcase
        grav = GRAVITY_TAB[idx];
        dlen = DUCK_TAB[idx];
        jmp  = JUMP_TAB[idx];
        step = STEP_TAB[idx];
    endtask

    task automatic model_reset();
        m_lane = `START_LANE;
        m_height = 0;
        m_vel = 0;
        m_dcnt = 0;
        m_score = 0;
        m_step = 1;
        m_go = 1'b0;
        m_prev = 4'b0000;
        m_track.delete();
    endtask

    // one frame of the game rules
    task automatic model_frame(input logic [3:0] spd, input logic [3:0] ctl);
        int        grav, dlen, jmp, step, vs, sum;
        logic [3:0] edges;
        logic      hit;
        obstacle_t o;
        obstacle_t kept[$];
        speed_table(spd, grav, dlen, jmp, step);
        edges = ctl & ~m_prev;
        m_prev = ctl;
        if (!m_go) begin
            if (edges[3] && !edges[0] && m_lane > 0) m_lane--;
            else if (edges[0] && !edges[3] && m_lane < `LANE_COUNT - 1) m_lane++;
            vs = (edges[1] && m_height == 0) ? jmp : m_vel;  // jump only from the ground
            sum = m_height + vs;
            if (sum <= 0) begin
                m_height = 0;
                m_vel = 0;
            end else begin
                m_height = (sum > 2047) ? 2047 : sum;  // top of the signed 12 bit range
                m_vel = vs - grav;
            end
            if (edges[2]) m_dcnt = dlen;
            else if (m_dcnt > 0) m_dcnt--;
            m_step = step;
        end
        foreach (m_track[i]) begin
            o = m_track[i];
            if (o.depth != 0) begin            // a slot at depth 0 was passed and is freed
                o.depth = (o.depth > step) ? o.depth - `DEPTH_W'(step) : '0;
                kept.push_back(o);
            end
        end
        m_track = kept;
        hit = 1'b0;
        foreach (m_track[i]) begin
            if (m_track[i].depth == 0 && int'(m_track[i].lane) == m_lane) begin
                case (m_track[i].kind)
                    KIND_LOW:   if (m_height < `LOW_CLEAR) hit = 1'b1;
                    KIND_HIGH:  if (m_dcnt == 0) hit = 1'b1;
                    KIND_TRAIN: if (m_height < `TRAIN_TOP) hit = 1'b1;
                    default:    ;
                endcase
            end
        end
        if (hit) m_go = 1'b1;
        if (!m_go) m_score += m_step;
    endtask

    task automatic check_status(input logic [1:0] lane, input logic duck, input logic go,
                                input int row);
        runner_status_t exp;
        exp.game_over = go;
        exp.lane = lane;
        exp.height = `HEIGHT_W'(m_height);
        exp.ducking = duck;
        exp.score = `SCORE_W'(m_score);
        checks++;
        assert (status === exp) else begin
            errors++;
            $display("ERR %0t: row %0d status %h, expected %h", $time, row, status, exp);
        end
    endtask

    task automatic wait_frame();
        do @(negedge clk_render); while (!frame_done);  // status stable until next frame
    endtask

    task automatic model_check(input int row);
        check_status(2'(m_lane), m_dcnt != 0, m_go, row);
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        speed <= 4'd1;
        controls <= '0;
        frame_gap <= `GAP_W'(1);
        obstacle_in <= '0;
        obstacle_in_valid <= 1'b0;
        repeat (2) @(posedge clk_render);
        reset <= 1'b0;
        model_reset();
        wait_frame();                       // first frame runs with idle inputs
        model_frame(4'd1, BTN_NONE);
        model_check(-1);
    endtask

    task automatic load_obstacle(input obstacle_t o);
        @(posedge clk_render);
        obstacle_in <= o;
        obstacle_in_valid <= 1'b1;
        do @(negedge clk_render); while (!obstacle_in_ready);
        @(posedge clk_render);
        obstacle_in_valid <= 1'b0;
        m_track.push_back(o);
    endtask

    task automatic add_row(input logic rst, input logic [3:0] spd, input logic [3:0] ctl,
                           input int frames, input obstacle_t obs, input int lane,
                           input logic duck, input logic go);
        rows.push_back(row_t'{rst, spd, ctl, 8'(frames), obs, 2'(lane), duck, go});
    endtask

    task automatic build_table();
        add_row(0, 1, BTN_RIGHT, 1, NO_OBS, 2, 0, 0);           // lane edges and clamps
        add_row(0, 1, BTN_RIGHT, 3, NO_OBS, 2, 0, 0);
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 2, 0, 0);
        add_row(0, 1, BTN_RIGHT, 1, NO_OBS, 2, 0, 0);           // clamped at lane 2
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 2, 0, 0);
        add_row(0, 1, BTN_LEFT, 2, NO_OBS, 1, 0, 0);            // held, moves only once
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 1, 0, 0);
        add_row(0, 1, BTN_LEFT | BTN_RIGHT, 1, NO_OBS, 1, 0, 0);  // both edges cancel
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 1, 0, 0);
        add_row(0, 1, BTN_LEFT, 1, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_LEFT, 1, NO_OBS, 0, 0, 0);            // clamped at lane 0
        add_row(0, 1, BTN_NONE, 1, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_JUMP, 1, NO_OBS, 0, 0, 0);           // slow jump
        add_row(0, 1, BTN_NONE, 10, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_JUMP, 1, NO_OBS, 0, 0, 0);           // ignored in mid air
        add_row(0, 1, BTN_NONE, 215, NO_OBS, 0, 0, 0);
        add_row(0, 4, BTN_JUMP, 1, NO_OBS, 0, 0, 0);           // fast jump
        add_row(0, 4, BTN_NONE, 80, NO_OBS, 0, 0, 0);
        add_row(0, 8, BTN_DUCK, 1, NO_OBS, 0, 1, 0);           // 16 frame duck
        add_row(0, 8, BTN_NONE, 15, NO_OBS, 0, 1, 0);
        add_row(0, 8, BTN_NONE, 1, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_NONE, 1, mk_obs(KIND_HIGH, 1, 1), 0, 0, 0);   // other lanes
        add_row(0, 1, BTN_NONE, 1, mk_obs(KIND_TRAIN, 2, 1), 0, 0, 0);
        add_row(0, 1, BTN_JUMP, 1, mk_obs(KIND_LOW, 0, 1), 0, 0, 0);    // jumped over
        add_row(0, 1, BTN_NONE, 230, NO_OBS, 0, 0, 0);
        add_row(0, 8, BTN_DUCK, 1, mk_obs(KIND_HIGH, 0, 8), 0, 1, 0);   // ducked under
        add_row(0, 8, BTN_NONE, 15, NO_OBS, 0, 1, 0);
        add_row(0, 8, BTN_NONE, 1, NO_OBS, 0, 0, 0);
        add_row(0, 4, BTN_JUMP, 1, mk_obs(KIND_TRAIN, 0, 4), 0, 0, 0);  // onto the roof
        add_row(0, 4, BTN_NONE, 80, NO_OBS, 0, 0, 0);
        add_row(0, 1, BTN_NONE, 1, mk_obs(KIND_LOW, 0, 1), 0, 0, 1);    // hit
        add_row(0, 1, BTN_RIGHT | BTN_JUMP, 2, NO_OBS, 0, 0, 1);  // frozen player
        add_row(1, 1, BTN_NONE, 1, mk_obs(KIND_HIGH, 1, 1), 1, 0, 1);
        add_row(1, 1, BTN_NONE, 1, mk_obs(KIND_TRAIN, 1, 1), 1, 0, 1);
    endtask

    initial begin
        int               frames_total;
        int               frames_waited;
        logic [`GAP_W-1:0] gap;
        build_table();
        frames_total = 6;                   // initial frame plus the fill phase
        foreach (rows[i]) frames_total += int'(rows[i].frames) + int'(rows[i].rst);
        cycle_limit = frames_total * (`TRACK_SLOTS + 20 + 15) + 50 + 2 * 80 + 40;

        apply_reset();
        foreach (rows[r]) begin
            @(posedge clk_render);
            if (rows[r].rst) begin
                apply_reset();
                @(posedge clk_render);
            end
            pick_gap(gap);
            speed <= rows[r].speed;
            controls <= controls_t'(rows[r].ctl);
            frame_gap <= gap;
            if (rows[r].obs.kind != KIND_NONE) begin
                obstacle_in <= rows[r].obs;
                obstacle_in_valid <= 1'b1;
                do @(negedge clk_render); while (!obstacle_in_ready);
                @(posedge clk_render);
                obstacle_in_valid <= 1'b0;
                m_track.push_back(rows[r].obs);
            end
            for (int f = 0; f < int'(rows[r].frames); f++) begin
                wait_frame();
                model_frame(rows[r].speed, rows[r].ctl);
                check_status(rows[r].lane, rows[r].duck, rows[r].go, r);
            end
        end

        // fill all slots during one long gap
        @(posedge clk_render);
        speed <= 4'd1;
        controls <= '0;
        frame_gap <= `GAP_W'(80);
        wait_frame();
        model_frame(4'd1, BTN_NONE);
        model_check(-2);
        for (int i = 0; i < `TRACK_SLOTS; i++) load_obstacle(mk_obs(KIND_LOW, 0, 2));
        @(posedge clk_render);
        obstacle_in <= mk_obs(KIND_TRAIN, 2, 3);
        obstacle_in_valid <= 1'b1;
        frame_gap <= `GAP_W'(1);
        @(negedge clk_render);
        checks++;
        assert (!obstacle_in_ready) else begin
            errors++;
            $display("ERR %0t: store accepted a word while all slots were full", $time);
        end
        frames_waited = 0;
        do begin
            @(negedge clk_render);
            if (frame_done) begin
                model_frame(4'd1, BTN_NONE);
                model_check(-3);
                frames_waited++;
            end
        end while (!obstacle_in_ready);
        @(posedge clk_render);
        obstacle_in_valid <= 1'b0;
        m_track.push_back(mk_obs(KIND_TRAIN, 2, 3));
        checks++;
        assert (frames_waited == 3) else begin
            errors++;
            $display("ERR %0t: held word taken after %0d frames, expected 3", $time,
                     frames_waited);
        end
        wait_frame();
        model_frame(4'd1, BTN_NONE);
        model_check(-4);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/collision_judge.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module collision_judge (
    input  logic                  clk_render,
    input  logic                  reset,
    input  runner_pkg::player_t   player,
    input  runner_pkg::obstacle_t scan_obstacle,
    input  logic                  scan_valid,
    input  logic                  scan_done,
    output logic                  game_over,
    output logic [`SCORE_W-1:0]   score
);

    import runner_pkg::*;

    logic level;  // obstacle has reached the player in the player's lane
    logic hit;

    assign level = (scan_obstacle.depth == '0) && (scan_obstacle.lane == player.lane);

    // each kind has its own way to be cleared
    always_comb begin
        case (scan_obstacle.kind)
            KIND_LOW:   hit = level && (player.height < `LOW_CLEAR);
            KIND_HIGH:  hit = level && !player.ducking;
            KIND_TRAIN: hit = level && (player.height < `TRAIN_TOP);
            default:    hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_render) begin
        if (reset) begin
            game_over <= 1'b0;
            score     <= '0;
        end else begin
            if (scan_valid && hit) game_over <= 1'b1;  // sticky until reset

            // the whole scan is judged before the frame scores
            if (scan_done && !game_over) score <= score + `SCORE_W'(player.step);
        end
    end

endmodule

//--- verilog/frame_sequencer.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module frame_sequencer (
    input  logic               clk_render,
    input  logic               reset,
    input  logic [`GAP_W-1:0]  frame_gap,
    input  logic               scan_done,
    output logic               frame_start,
    output logic               frame_done
);

    typedef enum logic [1:0] {
        ST_LAUNCH,    // issue frame_start
        ST_SCANNING,  // wait for the track scan to finish
        ST_GAP        // idle between frames
    } seq_state_e;

    seq_state_e         state;
    logic [`GAP_W-1:0]  gap_cnt;
    logic [`GAP_W-1:0]  gap_limit;
    logic               gap_over;

    // a gap of zero still idles one cycle
    assign gap_limit = (frame_gap == '0) ? `GAP_W'(1) : frame_gap;
    assign gap_over  = (gap_cnt >= gap_limit - 1'b1);

    always_ff @(posedge clk_render) begin
        if (reset) begin
            state       <= ST_GAP;
            gap_cnt     <= '1;    // saturated, so the first gap ends at once
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            frame_start <= 1'b0;  // both are single cycle pulses
            frame_done  <= 1'b0;
            case (state)
                ST_LAUNCH: begin
                    frame_start <= 1'b1;
                    state       <= ST_SCANNING;
                end
                ST_SCANNING: begin
                    if (scan_done) begin
                        frame_done <= 1'b1;  // status settles on the same edge
                        gap_cnt    <= '0;
                        state      <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (gap_over) state <= ST_LAUNCH;
                    else gap_cnt <= gap_cnt + 1'b1;
                end
                default: state <= ST_GAP;
            endcase
        end
    end

endmodule

//--- verilog/player_physics.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module player_physics (
    input  logic                  clk_render,
    input  logic                  reset,
    input  logic                  frame_start,
    input  logic [3:0]            speed,
    input  runner_pkg::controls_t controls,
    input  logic                  freeze,
    output runner_pkg::player_t   player
);

    import runner_pkg::*;

    localparam int HEIGHT_MAX = 2 ** (`HEIGHT_W - 1) - 1;

    controls_t                    ctrl_prev;   // sample from the previous frame
    controls_t                    ctrl_edge;
    logic [1:0]                   lane_q;
    logic [1:0]                   lane_next;
    logic signed [`HEIGHT_W-1:0]  height_q;
    logic signed [`HEIGHT_W-1:0]  height_next;
    logic signed [`HEIGHT_W-1:0]  velocity;
    logic signed [`HEIGHT_W-1:0]  vel_start;
    logic signed [`HEIGHT_W-1:0]  vel_next;
    logic signed [`HEIGHT_W+1:0]  height_sum;  // two spare bits for the overflow check
    logic signed [`HEIGHT_W-1:0]  gravity;
    logic signed [`HEIGHT_W-1:0]  jump_vel;
    logic [7:0]                   duck_len;
    logic [7:0]                   duck_cnt;
    logic [3:0]                   step_q;

    assign ctrl_edge = controls_t'(controls & ~ctrl_prev);  // rising edges only

    // difficulty table, faster pace means heavier gravity and shorter ducks
    always_comb begin
        case (speed)
            4'd2: begin
                gravity  = `HEIGHT_W'(4);
                duck_len = 8'd64;
                jump_vel = `HEIGHT_W'(220);
            end
            4'd4: begin
                gravity  = `HEIGHT_W'(15);
                duck_len = 8'd32;
                jump_vel = `HEIGHT_W'(470);
            end
            4'd8: begin
                gravity  = `HEIGHT_W'(60);
                duck_len = 8'd16;
                jump_vel = `HEIGHT_W'(360);
            end
            default: begin
                gravity  = `HEIGHT_W'(1);
                duck_len = 8'd128;
                jump_vel = `HEIGHT_W'(108);
            end
        endcase
    end

    // opposing edges in one frame cancel out
    always_comb begin
        lane_next = lane_q;
        if (ctrl_edge.left && !ctrl_edge.right && lane_q != 2'd0)
            lane_next = lane_q - 2'd1;
        else if (ctrl_edge.right && !ctrl_edge.left && lane_q != 2'(`LANE_COUNT - 1))
            lane_next = lane_q + 2'd1;
    end

    always_comb begin
        vel_start  = (ctrl_edge.jump && height_q == '0) ? jump_vel : velocity;  // only from ground
        height_sum = height_q + vel_start;
        if (height_sum <= 0) begin
            height_next = '0;   // landed
            vel_next    = '0;
        end else if (height_sum > HEIGHT_MAX) begin
            height_next = `HEIGHT_W'(HEIGHT_MAX);  // top of the height range
            vel_next    = vel_start - gravity;
        end else begin
            height_next = height_sum[`HEIGHT_W-1:0];
            vel_next    = vel_start - gravity;
        end
    end

    always_ff @(posedge clk_render) begin
        if (reset) begin
            ctrl_prev <= '0;
            lane_q    <= 2'(`START_LANE);
            height_q  <= '0;
            velocity  <= '0;
            duck_cnt  <= '0;
            step_q    <= 4'd1;
        end else if (frame_start) begin
            ctrl_prev <= controls;
            if (!freeze) begin
                lane_q   <= lane_next;
                height_q <= height_next;
                velocity <= vel_next;
                step_q   <= speed_step(speed);
                if (ctrl_edge.duck) duck_cnt <= duck_len;  // a new duck restarts the timer
                else if (duck_cnt != '0) duck_cnt <= duck_cnt - 1'b1;
            end
        end
    end

    assign player = '{lane: lane_q, height: height_q, ducking: (duck_cnt != '0), step: step_q};

endmodule

//--- verilog/runner_consts.svh
`ifndef RUNNER_CONSTS_SVH
`define RUNNER_CONSTS_SVH

// track geometry
`define TRACK_SLOTS 16      // obstacle slots held in the track store
`define DEPTH_W     12      // distance from obstacle to player

// lanes, numbered 0 (left) to LANE_COUNT-1 (right)
`define LANE_COUNT  3
`define START_LANE  1       // middle lane after reset

// player vertical state, signed
`define HEIGHT_W    12

// score counter
`define SCORE_W     16

// heights the player must reach to clear an obstacle
`define LOW_CLEAR   64      // low barrier
`define TRAIN_TOP   256     // roof of a train car

// idle cycles between frames
`define GAP_W       8

`endif

//--- verilog/runner_core.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module runner_core (
    input  logic                       clk_render,
    input  logic                       reset,
    input  logic [3:0]                 speed,
    input  runner_pkg::controls_t      controls,    // clean levels, no bounce
    input  logic [`GAP_W-1:0]          frame_gap,
    input  runner_pkg::obstacle_t      obstacle_in,
    input  logic                       obstacle_in_valid,
    output logic                       obstacle_in_ready,
    output runner_pkg::runner_status_t status,
    output logic                       frame_done
);

    import runner_pkg::*;

    logic                 frame_start;
    logic                 scan_valid;
    logic                 scan_done;
    logic                 game_over;
    logic [`SCORE_W-1:0]  score;
    obstacle_t            scan_obstacle;
    player_t              player;

    frame_sequencer u_sequencer (
        .clk_render  (clk_render),
        .reset       (reset),
        .frame_gap   (frame_gap),
        .scan_done   (scan_done),
        .frame_start (frame_start),
        .frame_done  (frame_done)
    );

    track_store u_track (
        .clk_render        (clk_render),
        .reset             (reset),
        .frame_start       (frame_start),
        .speed             (speed),
        .obstacle_in       (obstacle_in),
        .obstacle_in_valid (obstacle_in_valid),
        .obstacle_in_ready (obstacle_in_ready),
        .scan_obstacle     (scan_obstacle),
        .scan_valid        (scan_valid),
        .scan_done         (scan_done)
    );

    player_physics u_physics (
        .clk_render  (clk_render),
        .reset       (reset),
        .frame_start (frame_start),
        .speed       (speed),
        .controls    (controls),
        .freeze      (game_over),   // player stops moving once the game is lost
        .player      (player)
    );

    collision_judge u_judge (
        .clk_render    (clk_render),
        .reset         (reset),
        .player        (player),
        .scan_obstacle (scan_obstacle),
        .scan_valid    (scan_valid),
        .scan_done     (scan_done),
        .game_over     (game_over),
        .score         (score)
    );

    assign status = '{
        game_over: game_over,
        lane:      player.lane,
        height:    player.height,
        ducking:   player.ducking,
        score:     score
    };

endmodule

//--- verilog/runner_pkg.sv
`include "runner_consts.svh"

package runner_pkg;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,  // empty word, dropped on load
        KIND_LOW   = 2'd1,  // jump over it
        KIND_HIGH  = 2'd2,  // duck under it
        KIND_TRAIN = 2'd3   // climb on top or change lane
    } obstacle_kind_e;

    typedef struct packed {
        obstacle_kind_e      kind;
        logic [1:0]          lane;
        logic [`DEPTH_W-1:0] depth;  // 0 means level with the player
    } obstacle_t;

    // button order matches the board: left, duck, jump, right
    typedef struct packed {
        logic left;
        logic duck;
        logic jump;
        logic right;
    } controls_t;

    typedef struct packed {
        logic [1:0]                 lane;
        logic signed [`HEIGHT_W-1:0] height;
        logic                       ducking;
        logic [3:0]                 step;    // depth units per frame, also score per frame
    } player_t;

    typedef struct packed {
        logic                       game_over;
        logic [1:0]                 lane;
        logic signed [`HEIGHT_W-1:0] height;
        logic                       ducking;
        logic [`SCORE_W-1:0]        score;
    } runner_status_t;

    // speeds outside the table run at the slowest pace
    function automatic logic [3:0] speed_step(input logic [3:0] speed);
        case (speed)
            4'd2, 4'd4, 4'd8: speed_step = speed;
            default:          speed_step = 4'd1;
        endcase
    endfunction

endpackage

//--- verilog/track_store.sv
`timescale 1ns/100ps
`include "runner_consts.svh"

module track_store (
    input  logic                clk_render,
    input  logic                reset,
    input  logic                frame_start,
    input  logic [3:0]          speed,
    input  runner_pkg::obstacle_t obstacle_in,
    input  logic                obstacle_in_valid,
    output logic                obstacle_in_ready,
    output runner_pkg::obstacle_t scan_obstacle,
    output logic                scan_valid,
    output logic                scan_done
);

    import runner_pkg::*;

    localparam int SLOT_W = $clog2(`TRACK_SLOTS);

    obstacle_t                slot_q [`TRACK_SLOTS];  // obstacle payloads
    logic [`TRACK_SLOTS-1:0]  occupied;               // one flag per slot
    logic                     scanning;
    logic [SLOT_W-1:0]        scan_idx;
    logic [SLOT_W-1:0]        free_idx;
    logic                     all_full;
    logic                     load_fire;
    logic [3:0]               step;

    assign step = speed_step(speed);  // same pace the physics uses

    // lowest free slot, scanned from the top so index 0 wins
    always_comb begin
        free_idx = '0;
        for (int i = `TRACK_SLOTS - 1; i >= 0; i--) begin
            if (!occupied[i]) free_idx = SLOT_W'(i);
        end
    end

    assign all_full = &occupied;

    // no loading while the frame ages and scans the slots
    assign obstacle_in_ready = !all_full && !frame_start && !scanning && !scan_done;
    assign load_fire         = obstacle_in_valid && obstacle_in_ready;

    // scan stream, one slot per cycle, empty slots give no valid
    assign scan_obstacle = slot_q[scan_idx];
    assign scan_valid    = scanning && occupied[scan_idx];

    // payload path
    always_ff @(posedge clk_render) begin
        if (frame_start) begin
            for (int i = 0; i < `TRACK_SLOTS; i++) begin
                if (slot_q[i].depth > `DEPTH_W'(step))
                    slot_q[i].depth <= slot_q[i].depth - `DEPTH_W'(step);
                else
                    slot_q[i].depth <= '0;  // saturate at the player
            end
        end else if (load_fire) begin
            slot_q[free_idx] <= obstacle_in;
        end
    end

    // occupancy and scan control
    always_ff @(posedge clk_render) begin
        if (reset) begin
            occupied  <= '0;
            scanning  <= 1'b0;
            scan_idx  <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (frame_start) begin
                // an obstacle already at depth 0 was passed last frame
                for (int i = 0; i < `TRACK_SLOTS; i++) begin
                    if (slot_q[i].depth == '0) occupied[i] <= 1'b0;
                end
                scanning <= 1'b1;
                scan_idx <= '0;
            end else if (scanning) begin
                scan_idx <= scan_idx + 1'b1;  // wraps back to 0 after the last slot
                if (scan_idx == SLOT_W'(`TRACK_SLOTS - 1)) begin
                    scanning  <= 1'b0;
                    scan_done <= 1'b1;
                end
            end else if (load_fire && obstacle_in.kind != KIND_NONE) begin
                occupied[free_idx] <= 1'b1;  // kind none is taken but never stored
            end
        end
    end

endmodule
